/* rtl/vfe_controller.sv */
/*
 * Vector front end controller
 * Holds vl, vtype and vstart, runs config and CSR ops, issues arithmetic
 */
`timescale 1ns/1ps

module vfe_controller import vfe_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     dec_valid_i,
  input  dec_req_t dec_i,
  output logic     dec_pop_o,
  output logic     issue_valid_o,
  output vissue_t  issue_o,
  input  logic     issue_credit_i,
  output logic     rsp_push_o,
  output acc_rsp_t rsp_o,
  input  logic     rsp_full_i
);

  xlen_t      vl_q;
  xlen_t      vtype_q;
  xlen_t      vstart_q;
  icnt_t      credits_q;
  logic       is_arith;
  logic [2:0] cfg_sew;
  logic [2:0] cfg_lmul;
  logic       cfg_vill;
  xlen_t      vlmax;
  xlen_t      cfg_vl;
  xlen_t      csr_old;

  ////////////////////
  // Pop and issue
  ////////////////////

  assign is_arith = (dec_i.op != VCFG) && (dec_i.op != VCSR);
  assign dec_pop_o = dec_valid_i && !rsp_full_i &&
                     (dec_i.illegal || !is_arith || credits_q != '0);
  assign issue_valid_o = dec_pop_o && is_arith && !dec_i.illegal;
  assign rsp_push_o = dec_pop_o;

  assign issue_o = '{op: dec_i.op, vd: dec_i.vd, vs1: dec_i.vs1, vs2: dec_i.vs2,
                     use_vs1: dec_i.use_vs1, scalar: dec_i.scalar, vm: dec_i.vm,
                     vl: vl_q, vtype: vtype_q};

  ////////////////////
  // Config and CSR
  ////////////////////

  assign cfg_sew  = dec_i.cfg.vtype[5:3];
  assign cfg_lmul = dec_i.cfg.vtype[2:0];
  // SEW above 64 or fractional LMUL
  assign cfg_vill = cfg_sew[2] || cfg_lmul[2];
  assign vlmax = (xlen_t'(VLEN) << cfg_lmul) >> ({1'b0, cfg_sew} + 4'd3);

  always_comb begin
    if (cfg_vill) cfg_vl = '0;
    else if (dec_i.cfg.keep_vl) cfg_vl = vl_q;
    else cfg_vl = (dec_i.cfg.avl < vlmax) ? dec_i.cfg.avl : vlmax;
  end

  always_comb begin
    case (dec_i.csr.addr)
      CSR_VSTART: csr_old = vstart_q;
      CSR_VL:     csr_old = vl_q;
      CSR_VTYPE:  csr_old = vtype_q;
      default:    csr_old = xlen_t'(VLENB);
    endcase
  end

  always_comb begin
    rsp_o.rd = dec_i.rd;
    rsp_o.write = !dec_i.illegal && dec_i.use_rd;
    rsp_o.illegal = dec_i.illegal;
    if (dec_i.illegal) rsp_o.data = '0;
    else if (dec_i.op == VCFG) rsp_o.data = cfg_vl;
    else if (dec_i.op == VCSR) rsp_o.data = csr_old;
    else rsp_o.data = '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vl_q <= '0;
      vtype_q <= VTYPE_VILL;
      vstart_q <= '0;
      credits_q <= icnt_t'(ISSUE_CREDITS);
    end else begin
      credits_q <= credits_q + icnt_t'(issue_credit_i) - icnt_t'(issue_valid_o);
      if (dec_pop_o && !dec_i.illegal) begin
        case (dec_i.op)
          VCFG: begin
            vl_q <= cfg_vl;
            vtype_q <= cfg_vill ? VTYPE_VILL : xlen_t'(dec_i.cfg.vtype);
            // Every vector instruction but a CSR access restarts at element 0
            vstart_q <= '0;
          end
          VCSR: begin
            if (dec_i.csr.addr == CSR_VSTART) begin
              case (dec_i.csr.csr_op)
                CSR_SET:   vstart_q <= vstart_q | dec_i.csr.operand;
                CSR_CLEAR: vstart_q <= vstart_q & ~dec_i.csr.operand;
                default:   vstart_q <= dec_i.csr.operand;
              endcase
            end
          end
          default: vstart_q <= '0;
        endcase
      end
    end
  end

endmodule

/* rtl/vfe_credit_fifo.sv */
/*
 * Credit FIFO
 * Circular buffer of any packed payload, head registered one cycle after push
 */
`timescale 1ns/1ps

module vfe_credit_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem_q [DEPTH];
  ptr_t     rd_ptr_q;
  ptr_t     wr_ptr_q;
  cnt_t     count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      if (pop_i) rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      count_q <= count_q + cnt_t'(push_i) - cnt_t'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(DEPTH));

endmodule

/* rtl/vfe_decoder.sv */
/*
 * Vector instruction decoder
 * Splits an offloaded instruction into config, CSR or arithmetic fields
 */
`timescale 1ns/1ps

module vfe_decoder import vfe_pkg::*; (
  input  acc_req_t req_i,
  output dec_req_t dec_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [5:0]  funct6;
  logic [4:0]  rd_f;
  logic [4:0]  rs1_f;
  logic [4:0]  rs2_f;
  logic [11:0] csr_addr;
  logic        is_opm;
  logic        is_vi;
  logic        is_vv;

  assign opcode   = req_i.instr[6:0];
  assign funct3   = req_i.instr[14:12];
  assign funct6   = req_i.instr[31:26];
  assign rd_f     = req_i.instr[11:7];
  assign rs1_f    = req_i.instr[19:15];
  assign rs2_f    = req_i.instr[24:20];
  assign csr_addr = req_i.instr[31:20];
  assign is_opm   = (funct3 == OPMVV) || (funct3 == OPMVX);
  assign is_vi    = (funct3 == OPIVI);
  assign is_vv    = (funct3 == OPIVV);

  always_comb begin
    dec_o = '0;
    case (opcode)
      OPC_VEC: begin
        if (funct3 == OPCFG) begin
          dec_o.op = VCFG;
          dec_o.rd = rd_f;
          dec_o.use_rd = 1'b1;
          if (!req_i.instr[31]) begin
            dec_o.cfg.vtype = req_i.instr[27:20];
            dec_o.cfg.avl = req_i.rs1;
          end else if (req_i.instr[31:30] == 2'b11) begin
            dec_o.cfg.vtype = req_i.instr[27:20];
            dec_o.cfg.avl = xlen_t'(rs1_f);
          end else if (req_i.instr[31:25] == 7'b1000000) begin
            dec_o.cfg.vtype = req_i.rs2[7:0];
            dec_o.cfg.avl = req_i.rs1;
          end else begin
            dec_o.illegal = 1'b1;
          end
          // vsetivli takes its uimm as the AVL as is
          if (req_i.instr[31:30] != 2'b11) begin
            if (rs1_f == '0 && rd_f != '0) dec_o.cfg.avl = '1;
            dec_o.cfg.keep_vl = (rs1_f == '0) && (rd_f == '0);
          end
        end else begin
          dec_o.vd = rd_f;
          dec_o.vs2 = rs2_f;
          dec_o.vm = req_i.instr[25];
          case (funct3)
            OPIVV, OPMVV: begin
              dec_o.use_vs1 = 1'b1;
              dec_o.vs1 = rs1_f;
            end
            OPIVI: dec_o.scalar = {{27{rs1_f[4]}}, rs1_f};
            OPIVX, OPMVX: dec_o.scalar = req_i.rs1;
            default: dec_o.illegal = 1'b1;
          endcase

          if (is_opm) begin
            if (funct6 == F6_VMUL) dec_o.op = VMUL;
            else dec_o.illegal = 1'b1;
          end else begin
            case (funct6)
              F6_VADD: dec_o.op = VADD;
              F6_VSUB: begin
                dec_o.op = VSUB;
                if (is_vi) dec_o.illegal = 1'b1;
              end
              F6_VRSUB: begin
                dec_o.op = VRSUB;
                if (is_vv) dec_o.illegal = 1'b1;
              end
              F6_VMINU, F6_VMIN, F6_VMAXU, F6_VMAX: begin
                dec_o.op = (funct6 == F6_VMINU) ? VMINU :
                           (funct6 == F6_VMIN)  ? VMIN  :
                           (funct6 == F6_VMAXU) ? VMAXU : VMAX;
                if (is_vi) dec_o.illegal = 1'b1;
              end
              F6_VAND: dec_o.op = VAND;
              F6_VOR:  dec_o.op = VOR;
              F6_VXOR: dec_o.op = VXOR;
              F6_VSLL: dec_o.op = VSLL;
              F6_VSRL: dec_o.op = VSRL;
              F6_VSRA: dec_o.op = VSRA;
              // Unmasked with vs2 zero is vmv.v, anything else is vmerge
              F6_VMV: begin
                dec_o.op = VMV;
                if (!dec_o.vm || rs2_f != '0) dec_o.illegal = 1'b1;
              end
              default: dec_o.illegal = 1'b1;
            endcase
          end
        end
      end

      OPC_SYSTEM: begin
        dec_o.op = VCSR;
        dec_o.rd = rd_f;
        dec_o.use_rd = 1'b1;
        dec_o.csr.addr = csr_addr;
        dec_o.csr.operand = funct3[2] ? xlen_t'(rs1_f) : req_i.rs1;
        case (funct3[1:0])
          2'b01: dec_o.csr.csr_op = CSR_WRITE;
          2'b10: dec_o.csr.csr_op = CSR_SET;
          2'b11: dec_o.csr.csr_op = CSR_CLEAR;
          default: dec_o.illegal = 1'b1;
        endcase
        if (!(csr_addr inside {CSR_VSTART, CSR_VL, CSR_VTYPE, CSR_VLENB})) begin
          dec_o.illegal = 1'b1;
        end else if (csr_addr != CSR_VSTART && (funct3[1:0] == 2'b01 || rs1_f != '0)) begin
          // Read only CSRs
          dec_o.illegal = 1'b1;
        end
      end

      OPC_LOADFP, OPC_STOREFP: dec_o.illegal = 1'b1;

      default: dec_o.illegal = 1'b1;
    endcase
  end

endmodule

/* rtl/vfe_pkg.sv */
/*
 * Vector front end package
 * Widths, credit counts, RVV encodings and the request, issue and response types
 */
package vfe_pkg;

  localparam int unsigned VLEN = 256;
  localparam int unsigned VLENB = VLEN / 8;
  localparam int unsigned REQ_DEPTH = 4;
  localparam int unsigned RSP_DEPTH = 2;
  localparam int unsigned ISSUE_CREDITS = 2;

  ////////////////////
  // Encodings
  ////////////////////

  localparam logic [6:0] OPC_VEC = 7'h57;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;
  localparam logic [6:0] OPC_LOADFP = 7'h07;
  localparam logic [6:0] OPC_STOREFP = 7'h27;

  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;
  localparam logic [2:0] OPCFG = 3'b111;

  // OPI space, except VMUL which lives in OPM
  localparam logic [5:0] F6_VADD = 6'b000000;
  localparam logic [5:0] F6_VSUB = 6'b000010;
  localparam logic [5:0] F6_VRSUB = 6'b000011;
  localparam logic [5:0] F6_VMINU = 6'b000100;
  localparam logic [5:0] F6_VMIN = 6'b000101;
  localparam logic [5:0] F6_VMAXU = 6'b000110;
  localparam logic [5:0] F6_VMAX = 6'b000111;
  localparam logic [5:0] F6_VAND = 6'b001001;
  localparam logic [5:0] F6_VOR = 6'b001010;
  localparam logic [5:0] F6_VXOR = 6'b001011;
  localparam logic [5:0] F6_VMV = 6'b010111;
  localparam logic [5:0] F6_VSLL = 6'b100101;
  localparam logic [5:0] F6_VSRL = 6'b101000;
  localparam logic [5:0] F6_VSRA = 6'b101001;
  localparam logic [5:0] F6_VMUL = 6'b100101;

  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VL = 12'hc20;
  localparam logic [11:0] CSR_VTYPE = 12'hc21;
  localparam logic [11:0] CSR_VLENB = 12'hc22;

  localparam logic [31:0] VTYPE_VILL = 32'h8000_0000;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [31:0] xlen_t;
  typedef logic [$clog2(ISSUE_CREDITS+1)-1:0] icnt_t;
  typedef logic [$clog2(RSP_DEPTH+1)-1:0] rcnt_t;

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB, VAND, VOR, VXOR, VSLL, VSRL, VSRA,
    VMIN, VMINU, VMAX, VMAXU, VMUL, VMV, VCFG, VCSR
  } vop_e;

  typedef enum logic [1:0] {CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

  typedef struct packed {
    xlen_t instr;
    xlen_t rs1;
    xlen_t rs2;
  } acc_req_t;

  typedef struct packed {
    logic [7:0] vtype;
    xlen_t      avl;
    logic       keep_vl;
  } cfg_t;

  typedef struct packed {
    logic [11:0] addr;
    csr_op_e     csr_op;
    xlen_t       operand;
  } csr_t;

  typedef struct packed {
    vop_e       op;
    logic [4:0] rd;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic       use_vs1;
    logic       use_rd;
    xlen_t      scalar;
    logic       vm;
    cfg_t       cfg;
    csr_t       csr;
    logic       illegal;
  } dec_req_t;

  typedef struct packed {
    vop_e       op;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic       use_vs1;
    xlen_t      scalar;
    logic       vm;
    xlen_t      vl;
    xlen_t      vtype;
  } vissue_t;

  typedef struct packed {
    logic [4:0] rd;
    xlen_t      data;
    logic       write;
    logic       illegal;
  } acc_rsp_t;

endpackage

/* rtl/vfe_top.sv */
/*
 * Vector front end top
 * Request queue, decoder, controller and credited response queue
 */
`timescale 1ns/1ps

module vfe_top import vfe_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     req_valid_i,
  input  acc_req_t req_i,
  output logic     req_credit_o,
  output logic     issue_valid_o,
  output vissue_t  issue_o,
  input  logic     issue_credit_i,
  output logic     rsp_valid_o,
  output acc_rsp_t rsp_o,
  input  logic     rsp_credit_i
);

  acc_req_t req_head;
  logic     req_empty;
  dec_req_t dec;
  logic     dec_pop;
  acc_rsp_t rsp_data;
  logic     rsp_push;
  logic     rsp_full;
  logic     rsp_empty;
  rcnt_t    rsp_credits_q;

  vfe_credit_fifo #(.payload_t(acc_req_t), .DEPTH(REQ_DEPTH)) u_req_q (
    .clk_i(clk_i), .rst_i(rst_i),
    .push_i(req_valid_i), .data_i(req_i), .pop_i(dec_pop),
    .data_o(req_head), .empty_o(req_empty), .full_o()
  );

  vfe_decoder u_dec (.req_i(req_head), .dec_o(dec));

  vfe_controller u_ctrl (
    .clk_i(clk_i), .rst_i(rst_i),
    .dec_valid_i(!req_empty), .dec_i(dec), .dec_pop_o(dec_pop),
    .issue_valid_o(issue_valid_o), .issue_o(issue_o), .issue_credit_i(issue_credit_i),
    .rsp_push_o(rsp_push), .rsp_o(rsp_data), .rsp_full_i(rsp_full)
  );

  vfe_credit_fifo #(.payload_t(acc_rsp_t), .DEPTH(RSP_DEPTH)) u_rsp_q (
    .clk_i(clk_i), .rst_i(rst_i),
    .push_i(rsp_push), .data_i(rsp_data), .pop_i(rsp_valid_o),
    .data_o(rsp_o), .empty_o(rsp_empty), .full_o(rsp_full)
  );

  // Core gets a request credit back per pop
  assign req_credit_o = dec_pop;

  // Response leaves only against a core credit
  assign rsp_valid_o = !rsp_empty && (rsp_credits_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_credits_q <= rcnt_t'(RSP_DEPTH);
    end else begin
      rsp_credits_q <= rsp_credits_q + rcnt_t'(rsp_credit_i) - rcnt_t'(rsp_valid_o);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the vector front end testbench with Verilator
# Exit status is the simulation verdict

rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vfe_top -Mdir obj_dir -f src.f &&
./obj_dir/Vtb_vfe_top ||
exit 1

/* src.f */
rtl/vfe_pkg.sv
rtl/vfe_credit_fifo.sv
rtl/vfe_decoder.sv
rtl/vfe_controller.sv
rtl/vfe_top.sv
tb/vfe_assertions.sv
tb/tb_vfe_top.sv

/* tb/tb_vfe_top.sv */
/*
 * Vector front end testbench
 * Table driven requests with randomly delayed issue and response credits
 */
`timescale 1ns/1ps

module tb_vfe_top import vfe_pkg::*; ();

  typedef struct packed {
    xlen_t instr;
    xlen_t rs1;
    xlen_t rs2;
    logic [4:0] rd;
    xlen_t data;
    logic write;
    logic illegal;
    logic has_issue;
    vop_e op;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic use_vs1;
    xlen_t scalar;
    logic vm;
    xlen_t vl;
    xlen_t vtype;
  } row_t;

  logic clk_i;
  logic rst_i;
  logic req_valid_i;
  acc_req_t req_i;
  logic req_credit_o;
  logic issue_valid_o;
  vissue_t issue_o;
  logic issue_credit_i;
  logic rsp_valid_o;
  acc_rsp_t rsp_o;
  logic rsp_credit_i;

  row_t table_q[$];
  xlen_t exp_vl;
  xlen_t exp_vtype;
  int unsigned n_issue;
  int unsigned rsp_count;
  int unsigned iss_count;
  logic started;

  vfe_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic xlen_t enc_vsetvli(logic [4:0] rd, logic [4:0] rs1, logic [7:0] vt);
    return {4'b0000, vt, rs1, 3'b111, rd, 7'h57};
  endfunction

  function automatic xlen_t enc_vsetvl(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b1000000, rs2, rs1, 3'b111, rd, 7'h57};
  endfunction

  function automatic xlen_t enc_varith(logic [5:0] f6, logic vm, logic [4:0] vs2,
                                       logic [4:0] src, logic [2:0] f3, logic [4:0] vd);
    return {f6, vm, vs2, src, f3, vd, 7'h57};
  endfunction

  function automatic xlen_t enc_csr(logic [11:0] csr, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd);
    return {csr, rs1, f3, rd, 7'h73};
  endfunction

  task automatic add_rsp(input xlen_t instr, input xlen_t rs1, input xlen_t rs2,
                         input logic [4:0] rd, input xlen_t data, input logic write,
                         input logic illegal);
    row_t r;
    r = '0;
    r.instr = instr;
    r.rs1 = rs1;
    r.rs2 = rs2;
    r.rd = rd;
    r.data = data;
    r.write = write;
    r.illegal = illegal;
    table_q.push_back(r);
  endtask

  task automatic add_issue(input xlen_t instr, input xlen_t rs1, input vop_e op,
                           input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2,
                           input logic use_vs1, input xlen_t scalar, input logic vm);
    row_t r;
    r = '0;
    r.instr = instr;
    r.rs1 = rs1;
    r.has_issue = 1'b1;
    r.op = op;
    r.vd = vd;
    r.vs1 = vs1;
    r.vs2 = vs2;
    r.use_vs1 = use_vs1;
    r.scalar = scalar;
    r.vm = vm;
    r.vl = exp_vl;
    r.vtype = exp_vtype;
    table_q.push_back(r);
    n_issue++;
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic build_table();
    // VLMAX = VLEN * LMUL / SEW
    add_rsp(enc_vsetvli(1, 2, 8'h10), 100, 0, 1, 8, 1, 0);
    add_rsp(enc_vsetvli(1, 2, 8'h01), 5, 0, 1, 5, 1, 0);
    add_rsp(enc_vsetvli(3, 0, 8'h0b), 0, 0, 3, 128, 1, 0);
    add_rsp(enc_vsetvli(0, 0, 8'h18), 0, 0, 0, 128, 1, 0);
    add_rsp(enc_csr(CSR_VL, 0, 3'b010, 5), 0, 0, 5, 128, 1, 0);
    add_rsp(enc_csr(CSR_VTYPE, 0, 3'b010, 6), 0, 0, 6, 32'h18, 1, 0);
    add_rsp(enc_csr(CSR_VLENB, 0, 3'b010, 7), 0, 0, 7, 32, 1, 0);
    // SEW 128 and LMUL 1/8 both give vill
    add_rsp(enc_vsetvl(1, 2, 3), 10, 32'h20, 1, 0, 1, 0);
    add_rsp(enc_csr(CSR_VTYPE, 0, 3'b010, 6), 0, 0, 6, 32'h8000_0000, 1, 0);
    add_rsp(enc_vsetvli(1, 2, 8'h05), 3, 0, 1, 0, 1, 0);
    add_rsp(enc_csr(CSR_VTYPE, 0, 3'b010, 6), 0, 0, 6, 32'h8000_0000, 1, 0);
    add_rsp(enc_vsetvli(1, 2, 8'h10), 20, 0, 1, 8, 1, 0);
    add_rsp(enc_csr(CSR_VSTART, 2, 3'b001, 8), 5, 0, 8, 0, 1, 0);
    add_rsp(enc_csr(CSR_VSTART, 2, 3'b010, 8), 32'h12, 0, 8, 5, 1, 0);
    add_rsp(enc_csr(CSR_VSTART, 2, 3'b011, 8), 3, 0, 8, 32'h17, 1, 0);
    add_rsp(enc_csr(CSR_VL, 2, 3'b001, 9), 77, 0, 9, 0, 0, 1);
    add_rsp(enc_csr(CSR_VL, 0, 3'b010, 9), 0, 0, 9, 8, 1, 0);
    exp_vl = 8;
    exp_vtype = 32'h10;
    add_issue(enc_varith(6'b000000, 1, 2, 3, 3'b000, 1), 0, VADD, 1, 3, 2, 1, 0, 1);
    add_rsp(enc_csr(CSR_VSTART, 0, 3'b010, 10), 0, 0, 10, 0, 1, 0);
    add_rsp(enc_csr(CSR_VSTART, 2, 3'b001, 10), 7, 0, 10, 0, 1, 0);
    add_issue(enc_varith(6'b000010, 0, 5, 2, 3'b100, 4), 32'h1234, VSUB, 4, 0, 5, 0,
              32'h1234, 0);
    add_issue(enc_varith(6'b000000, 1, 7, 5'd29, 3'b011, 6), 0, VADD, 6, 0, 7, 0,
              32'hffff_fffd, 1);
    add_issue(enc_varith(6'b101001, 1, 9, 5, 3'b011, 8), 0, VSRA, 8, 0, 9, 0, 5, 1);
    add_issue(enc_varith(6'b100101, 1, 11, 2, 3'b110, 10), 9, VMUL, 10, 0, 11, 0, 9, 1);
    add_issue(enc_varith(6'b000011, 1, 12, 2, 3'b100, 13), 32'hdead, VRSUB, 13, 0, 12, 0,
              32'hdead, 1);
    add_issue(enc_varith(6'b000101, 0, 14, 15, 3'b000, 16), 0, VMIN, 16, 15, 14, 1, 0, 0);
    add_issue(enc_varith(6'b001011, 1, 2, 1, 3'b011, 1), 0, VXOR, 1, 0, 2, 0, 1, 1);
    add_rsp(enc_csr(CSR_VSTART, 0, 3'b010, 11), 0, 0, 11, 0, 1, 0);
    // Loads, stores, floating point, divide, unknown and vsub.vi
    add_rsp(32'h0000_7007, 0, 0, 0, 0, 0, 1);
    add_rsp(32'h0000_7027, 0, 0, 0, 0, 0, 1);
    add_rsp(enc_varith(6'b000000, 1, 2, 3, 3'b001, 1), 0, 0, 0, 0, 0, 1);
    add_rsp(enc_varith(6'b100000, 1, 2, 3, 3'b010, 1), 0, 0, 0, 0, 0, 1);
    add_rsp(32'h0000_0033, 0, 0, 0, 0, 0, 1);
    add_rsp(enc_varith(6'b000010, 1, 2, 3, 3'b011, 1), 0, 0, 0, 0, 0, 1);
  endtask

  ////////////////////
  // Request driver
  ////////////////////

  initial begin
    int unsigned credits;
    int unsigned idx;
    credits = REQ_DEPTH;
    idx = 0;
    wait (started);
    while (idx < table_q.size()) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      if (credits > 0 && $urandom_range(3) != 0) begin
        req_valid_i = 1'b1;
        req_i = '{instr: table_q[idx].instr, rs1: table_q[idx].rs1, rs2: table_q[idx].rs2};
        credits--;
        idx++;
      end
      // A returned credit is usable from the next cycle on
      if (req_credit_o) credits++;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  end

  // Responses in table order, credits returned after a random delay
  initial begin
    int unsigned pending;
    row_t r;
    pending = 0;
    wait (started);
    forever begin
      @(negedge clk_i);
      if (rsp_valid_o) begin
        if (rsp_count >= table_q.size()) fail_plain("Response arrived with no request left");
        r = table_q[rsp_count];
        check_value("rsp_o.write", xlen_t'(rsp_o.write), xlen_t'(r.write));
        check_value("rsp_o.illegal", xlen_t'(rsp_o.illegal), xlen_t'(r.illegal));
        if (r.write) begin
          check_value("rsp_o.rd", xlen_t'(rsp_o.rd), xlen_t'(r.rd));
          check_value("rsp_o.data", rsp_o.data, r.data);
        end
        rsp_count++;
        pending++;
      end
      if (pending > 0 && $urandom_range(3) == 0) begin
        rsp_credit_i = 1'b1;
        pending--;
      end else begin
        rsp_credit_i = 1'b0;
      end
    end
  end

  // Issues matched against arithmetic rows in order
  initial begin
    int unsigned pending;
    int unsigned ptr;
    row_t r;
    pending = 0;
    ptr = 0;
    wait (started);
    forever begin
      @(negedge clk_i);
      if (issue_valid_o) begin
        while (ptr < table_q.size() && !table_q[ptr].has_issue) ptr++;
        if (ptr >= table_q.size()) fail_plain("Issue arrived with no arithmetic request left");
        r = table_q[ptr];
        check_value("issue_o.op", xlen_t'(issue_o.op), xlen_t'(r.op));
        check_value("issue_o.vd", xlen_t'(issue_o.vd), xlen_t'(r.vd));
        check_value("issue_o.vs2", xlen_t'(issue_o.vs2), xlen_t'(r.vs2));
        check_value("issue_o.use_vs1", xlen_t'(issue_o.use_vs1), xlen_t'(r.use_vs1));
        if (r.use_vs1) check_value("issue_o.vs1", xlen_t'(issue_o.vs1), xlen_t'(r.vs1));
        else check_value("issue_o.scalar", issue_o.scalar, r.scalar);
        check_value("issue_o.vm", xlen_t'(issue_o.vm), xlen_t'(r.vm));
        check_value("issue_o.vl", issue_o.vl, r.vl);
        check_value("issue_o.vtype", issue_o.vtype, r.vtype);
        ptr++;
        iss_count++;
        pending++;
      end
      if (pending > 0 && $urandom_range(3) == 0) begin
        issue_credit_i = 1'b1;
        pending--;
      end else begin
        issue_credit_i = 1'b0;
      end
    end
  end

  initial begin
    wait (started);
    repeat (table_q.size() * 50) @(posedge clk_i);
    $display("Timeout: responses did not all arrive in time");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'hef83_0806));
    started = 1'b0;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    issue_credit_i = 1'b0;
    rsp_credit_i = 1'b0;
    n_issue = 0;
    rsp_count = 0;
    iss_count = 0;
    build_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    started = 1'b1;
    wait (rsp_count == table_q.size());
    repeat (20) @(negedge clk_i);
    if (iss_count == n_issue && rsp_count == table_q.size()) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Issue count %0d differs from expected %0d", iss_count, n_issue);
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

/* tb/vfe_assertions.sv */
/*
 * Vector front end assertions
 * Credit and queue handshake rules, bound into the top level
 */
`timescale 1ns/1ps

module vfe_assertions import vfe_pkg::*; (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           req_valid_i,
  input logic                           req_full_i,
  input logic [$clog2(REQ_DEPTH+1)-1:0] req_count_i,
  input logic                           rsp_push_i,
  input logic                           rsp_full_i,
  input logic                           issue_valid_i,
  input icnt_t                          issue_credits_i,
  input logic                           req_credit_i
);

  a_req_push_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> !req_full_i) else $error("request queue pushed while full");

  a_rsp_push_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_push_i |-> !rsp_full_i) else $error("response queue pushed while full");

  a_issue_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_valid_i |-> (issue_credits_i != '0)) else $error("issue without credit");

  // Queue occupancy moves by pushes in and credited pops out
  a_req_credit_is_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    1'b1 |=> req_count_i == $past(req_count_i) + $past(req_valid_i) - $past(req_credit_i))
    else $error("request credit differs from queue pop");

endmodule

bind vfe_top vfe_assertions u_assert (
  .clk_i(clk_i), .rst_i(rst_i),
  .req_valid_i(req_valid_i), .req_full_i(u_req_q.full_o),
  .req_count_i(u_req_q.count_q),
  .rsp_push_i(rsp_push), .rsp_full_i(rsp_full),
  .issue_valid_i(issue_valid_o), .issue_credits_i(u_ctrl.credits_q),
  .req_credit_i(req_credit_o)
);
